//--- rtl/graph_ctrl_pkg.sv
package graph_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////

	// Vertex id carried on jobs and read commands
	localparam int VERTEX_W = 16;

	// Edge count of one vertex
	localparam int DEGREE_W = 8;

	// Vertex and edge done counters
	localparam int COUNT_W = 24;

	////////////////////////////////////////////////////////////
	// Default sizes
	////////////////////////////////////////////////////////////

	localparam int NUM_CU_DEFAULT    = 4;
	localparam int JOB_DEPTH_DEFAULT = 8;
	localparam int CMD_DEPTH_DEFAULT = 4;

	// Free entries still left when almost-full rises
	localparam int ALMOST_FULL_MARGIN = 2;

endpackage

//--- rtl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             alfull
);
	import graph_ctrl_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Storage, no reset needed
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Head entry shows without a pop request
	assign data_out = mem[rd_ptr];

	assign empty  = (count == '0);
	assign full   = (count == CNT_W'(DEPTH));
	assign alfull = (int'(count) >= DEPTH - ALMOST_FULL_MARGIN);

endmodule

//--- rtl/rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter #(
	parameter int N = 4
) (
	input  logic         clock,
	input  logic         rstn,
	input  logic [N-1:0] request,
	input  logic         advance,
	output logic [N-1:0] grant
);

	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	logic [PTR_W-1:0] prio_ptr;
	logic [PTR_W-1:0] grant_idx;
	logic             found;

	// Scan from the priority pointer, wrapping around
	always_comb begin
		int idx;
		grant     = '0;
		grant_idx = '0;
		found     = 1'b0;
		for (int off = 0; off < N; off++) begin
			idx = int'(prio_ptr) + off;
			if (idx >= N) begin
				idx = idx - N;
			end
			if (!found && request[idx]) begin
				found      = 1'b1;
				grant[idx] = 1'b1;
				grant_idx  = PTR_W'(idx);
			end
		end
	end

	// Winner drops to lowest priority
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			prio_ptr <= '0;
		end else if (advance && found) begin
			prio_ptr <= (grant_idx == PTR_W'(N - 1)) ? '0 : grant_idx + 1'b1;
		end
	end

endmodule

//--- rtl/vertex_dispatch.sv
`timescale 1ns/1ns

module vertex_dispatch #(
	parameter int NUM_CU    = graph_ctrl_pkg::NUM_CU_DEFAULT,
	parameter int JOB_DEPTH = graph_ctrl_pkg::JOB_DEPTH_DEFAULT
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                vertex_valid,
	input  logic [graph_ctrl_pkg::VERTEX_W-1:0] vertex_id,
	input  logic [graph_ctrl_pkg::DEGREE_W-1:0] vertex_degree,
	input  logic [NUM_CU-1:0]                   idle,
	output logic                                vertex_stall,
	output logic [NUM_CU-1:0]                   job_valid,
	output logic [graph_ctrl_pkg::VERTEX_W-1:0] job_vertex,
	output logic [graph_ctrl_pkg::DEGREE_W-1:0] job_degree
);
	import graph_ctrl_pkg::*;

	localparam int JOB_W = VERTEX_W + DEGREE_W;

	logic [JOB_W-1:0]  job_head;
	logic              job_empty;
	logic              job_alfull;
	logic              job_pop;
	logic [NUM_CU-1:0] unit_request;

	////////////////////////////////////////////////////////////
	// Vertex job buffer
	////////////////////////////////////////////////////////////

	sync_fifo #(
		.WIDTH(JOB_W),
		.DEPTH(JOB_DEPTH)
	) job_fifo_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_valid),
		.data_in ({vertex_id, vertex_degree}),
		.pop     (job_pop),
		.data_out(job_head),
		.empty   (job_empty),
		.full    (),
		.alfull  (job_alfull)
	);

	// Stall seen by the source one cycle late, margin covers it
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_stall <= 1'b0;
		end else begin
			vertex_stall <= job_alfull;
		end
	end

	////////////////////////////////////////////////////////////
	// Dispatch to idle units
	////////////////////////////////////////////////////////////

	assign unit_request = idle & {NUM_CU{!job_empty}};

	rr_arbiter #(
		.N(NUM_CU)
	) dispatch_arb_i (
		.clock  (clock),
		.rstn   (rstn),
		.request(unit_request),
		.advance(job_pop),
		.grant  (job_valid)
	);

	// Head leaves the buffer on the grant edge
	assign job_pop    = |job_valid;
	assign job_vertex = job_head[JOB_W-1:DEGREE_W];
	assign job_degree = job_head[DEGREE_W-1:0];

endmodule

//--- rtl/vertex_worker.sv
`timescale 1ns/1ns

module vertex_worker #(
	parameter int CU_ID = 0
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                job_valid,
	input  logic [graph_ctrl_pkg::VERTEX_W-1:0] job_vertex,
	input  logic [graph_ctrl_pkg::DEGREE_W-1:0] job_degree,
	input  logic                                cmd_room,
	input  logic                                rsp_hit,
	output logic                                idle,
	output logic                                cmd_push,
	output logic [graph_ctrl_pkg::VERTEX_W-1:0] cmd_vertex,
	output logic [graph_ctrl_pkg::COUNT_W-1:0]  vertex_count,
	output logic [graph_ctrl_pkg::COUNT_W-1:0]  edge_count
);
	import graph_ctrl_pkg::*;

	// FSM encoding
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_ISSUE = 2'd1;
	localparam logic [1:0] ST_WAIT  = 2'd2;

	logic [1:0]          state;
	logic [VERTEX_W-1:0] vertex_reg;
	logic [DEGREE_W-1:0] degree_reg;

	// Job held for the life of the request
	always_ff @(posedge clock) begin
		if (state == ST_IDLE && job_valid) begin
			vertex_reg <= job_vertex;
			degree_reg <= job_degree;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= ST_IDLE;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (job_valid) begin
						state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					// Wait here while the command buffer is nearly full
					if (cmd_room) begin
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (rsp_hit) begin
						vertex_count <= vertex_count + 1'b1;
						edge_count   <= edge_count + COUNT_W'(degree_reg);
						state        <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	assign idle       = (state == ST_IDLE);
	assign cmd_push   = (state == ST_ISSUE) && cmd_room;
	assign cmd_vertex = vertex_reg;

endmodule

//--- rtl/compute_array.sv
`timescale 1ns/1ns

module compute_array #(
	parameter int NUM_CU = graph_ctrl_pkg::NUM_CU_DEFAULT,
	localparam int CU_W  = (NUM_CU > 1) ? $clog2(NUM_CU) : 1
) (
	input  logic                                            clock,
	input  logic                                            rstn,
	input  logic [NUM_CU-1:0]                               job_valid,
	input  logic [graph_ctrl_pkg::VERTEX_W-1:0]             job_vertex,
	input  logic [graph_ctrl_pkg::DEGREE_W-1:0]             job_degree,
	input  logic [NUM_CU-1:0]                               cmd_room,
	input  logic                                            read_rsp_valid,
	input  logic [CU_W-1:0]                                 read_rsp_cu,
	output logic [NUM_CU-1:0]                               idle,
	output logic [NUM_CU-1:0]                               cmd_push,
	output logic [NUM_CU-1:0][graph_ctrl_pkg::VERTEX_W-1:0] cmd_vertex,
	output logic [graph_ctrl_pkg::COUNT_W-1:0]              vertex_done_count,
	output logic [graph_ctrl_pkg::COUNT_W-1:0]              edge_done_count
);
	import graph_ctrl_pkg::*;

	logic [NUM_CU-1:0]  rsp_hit;
	logic [COUNT_W-1:0] vertex_count_cu [NUM_CU];
	logic [COUNT_W-1:0] edge_count_cu   [NUM_CU];
	logic [COUNT_W-1:0] vertex_sum;
	logic [COUNT_W-1:0] edge_sum;

	////////////////////////////////////////////////////////////
	// Response routing by unit id
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_hit <= '0;
		end else begin
			for (int i = 0; i < NUM_CU; i++) begin
				rsp_hit[i] <= read_rsp_valid && (read_rsp_cu == CU_W'(i));
			end
		end
	end

	genvar g;
	generate
		for (g = 0; g < NUM_CU; g++) begin : gen_worker
			vertex_worker #(
				.CU_ID(g)
			) worker_i (
				.clock       (clock),
				.rstn        (rstn),
				.job_valid   (job_valid[g]),
				.job_vertex  (job_vertex),
				.job_degree  (job_degree),
				.cmd_room    (cmd_room[g]),
				.rsp_hit     (rsp_hit[g]),
				.idle        (idle[g]),
				.cmd_push    (cmd_push[g]),
				.cmd_vertex  (cmd_vertex[g]),
				.vertex_count(vertex_count_cu[g]),
				.edge_count  (edge_count_cu[g])
			);
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Done counts summed over all units
	////////////////////////////////////////////////////////////

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			vertex_sum = vertex_sum + vertex_count_cu[i];
			edge_sum   = edge_sum + edge_count_cu[i];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			vertex_done_count <= vertex_sum;
			edge_done_count   <= edge_sum;
		end
	end

endmodule

//--- rtl/read_command_merge.sv
`timescale 1ns/1ns

module read_command_merge #(
	parameter int NUM_CU    = graph_ctrl_pkg::NUM_CU_DEFAULT,
	parameter int CMD_DEPTH = graph_ctrl_pkg::CMD_DEPTH_DEFAULT,
	localparam int CU_W     = (NUM_CU > 1) ? $clog2(NUM_CU) : 1
) (
	input  logic                                            clock,
	input  logic                                            rstn,
	input  logic [NUM_CU-1:0]                               cmd_push,
	input  logic [NUM_CU-1:0][graph_ctrl_pkg::VERTEX_W-1:0] cmd_vertex,
	input  logic                                            read_cmd_ready,
	output logic [NUM_CU-1:0]                               cmd_room,
	output logic                                            read_cmd_valid,
	output logic [graph_ctrl_pkg::VERTEX_W-1:0]             read_cmd_vertex,
	output logic [CU_W-1:0]                                 read_cmd_cu
);
	import graph_ctrl_pkg::*;

	logic [VERTEX_W-1:0] head_vertex [NUM_CU];
	logic [NUM_CU-1:0]   cmd_empty;
	logic [NUM_CU-1:0]   cmd_alfull;
	logic [NUM_CU-1:0]   merge_request;
	logic [NUM_CU-1:0]   merge_grant;
	logic                load_ok;
	logic [VERTEX_W-1:0] sel_vertex;
	logic [CU_W-1:0]     sel_cu;

	////////////////////////////////////////////////////////////
	// Per-unit command buffers
	////////////////////////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < NUM_CU; g++) begin : gen_cmd_fifo
			sync_fifo #(
				.WIDTH(VERTEX_W),
				.DEPTH(CMD_DEPTH)
			) cmd_fifo_i (
				.clock   (clock),
				.rstn    (rstn),
				.push    (cmd_push[g]),
				.data_in (cmd_vertex[g]),
				.pop     (merge_grant[g]),
				.data_out(head_vertex[g]),
				.empty   (cmd_empty[g]),
				.full    (),
				.alfull  (cmd_alfull[g])
			);
		end
	endgenerate

	assign cmd_room = ~cmd_alfull;

	////////////////////////////////////////////////////////////
	// Merge onto the command port
	////////////////////////////////////////////////////////////

	// Output register free or being taken this cycle
	assign load_ok       = !read_cmd_valid || read_cmd_ready;
	assign merge_request = ~cmd_empty & {NUM_CU{load_ok}};

	rr_arbiter #(
		.N(NUM_CU)
	) merge_arb_i (
		.clock  (clock),
		.rstn   (rstn),
		.request(merge_request),
		.advance(load_ok),
		.grant  (merge_grant)
	);

	always_comb begin
		sel_vertex = '0;
		sel_cu     = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			if (merge_grant[i]) begin
				sel_vertex = head_vertex[i];
				sel_cu     = CU_W'(i);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd_valid <= 1'b0;
		end else if (load_ok) begin
			read_cmd_valid <= |merge_grant;
		end
	end

	// Payload holds while the port is stalled
	always_ff @(posedge clock) begin
		if (load_ok && |merge_grant) begin
			read_cmd_vertex <= sel_vertex;
			read_cmd_cu     <= sel_cu;
		end
	end

endmodule

//--- rtl/graph_ctrl_top.sv
`timescale 1ns/1ns

module graph_ctrl_top #(
	parameter int NUM_CU    = graph_ctrl_pkg::NUM_CU_DEFAULT,
	parameter int JOB_DEPTH = graph_ctrl_pkg::JOB_DEPTH_DEFAULT,
	parameter int CMD_DEPTH = graph_ctrl_pkg::CMD_DEPTH_DEFAULT,
	localparam int CU_W     = (NUM_CU > 1) ? $clog2(NUM_CU) : 1
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                vertex_valid,
	input  logic [graph_ctrl_pkg::VERTEX_W-1:0] vertex_id,
	input  logic [graph_ctrl_pkg::DEGREE_W-1:0] vertex_degree,
	output logic                                vertex_stall,
	output logic                                read_cmd_valid,
	output logic [graph_ctrl_pkg::VERTEX_W-1:0] read_cmd_vertex,
	output logic [CU_W-1:0]                     read_cmd_cu,
	input  logic                                read_cmd_ready,
	input  logic                                read_rsp_valid,
	input  logic [CU_W-1:0]                     read_rsp_cu,
	output logic [graph_ctrl_pkg::COUNT_W-1:0]  vertex_done_count,
	output logic [graph_ctrl_pkg::COUNT_W-1:0]  edge_done_count
);
	import graph_ctrl_pkg::*;

	// Dispatch to workers
	logic [NUM_CU-1:0]   job_valid;
	logic [VERTEX_W-1:0] job_vertex;
	logic [DEGREE_W-1:0] job_degree;
	logic [NUM_CU-1:0]   idle;

	// Workers to command merge
	logic [NUM_CU-1:0]               cmd_push;
	logic [NUM_CU-1:0][VERTEX_W-1:0] cmd_vertex;
	logic [NUM_CU-1:0]               cmd_room;

	vertex_dispatch #(
		.NUM_CU   (NUM_CU),
		.JOB_DEPTH(JOB_DEPTH)
	) dispatch_i (
		.clock        (clock),
		.rstn         (rstn),
		.vertex_valid (vertex_valid),
		.vertex_id    (vertex_id),
		.vertex_degree(vertex_degree),
		.idle         (idle),
		.vertex_stall (vertex_stall),
		.job_valid    (job_valid),
		.job_vertex   (job_vertex),
		.job_degree   (job_degree)
	);

	compute_array #(
		.NUM_CU(NUM_CU)
	) compute_i (
		.clock            (clock),
		.rstn             (rstn),
		.job_valid        (job_valid),
		.job_vertex       (job_vertex),
		.job_degree       (job_degree),
		.cmd_room         (cmd_room),
		.read_rsp_valid   (read_rsp_valid),
		.read_rsp_cu      (read_rsp_cu),
		.idle             (idle),
		.cmd_push         (cmd_push),
		.cmd_vertex       (cmd_vertex),
		.vertex_done_count(vertex_done_count),
		.edge_done_count  (edge_done_count)
	);

	read_command_merge #(
		.NUM_CU   (NUM_CU),
		.CMD_DEPTH(CMD_DEPTH)
	) merge_i (
		.clock          (clock),
		.rstn           (rstn),
		.cmd_push       (cmd_push),
		.cmd_vertex     (cmd_vertex),
		.read_cmd_ready (read_cmd_ready),
		.cmd_room       (cmd_room),
		.read_cmd_valid (read_cmd_valid),
		.read_cmd_vertex(read_cmd_vertex),
		.read_cmd_cu    (read_cmd_cu)
	);

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Reset leaves on a rising edge
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

//--- test/tb_graph_ctrl.sv
`timescale 1ns/1ns

module tb_graph_ctrl;
	import graph_ctrl_pkg::*;

	localparam int NUM_CU    = 4;
	localparam int JOB_DEPTH = 8;
	localparam int CMD_DEPTH = 4;
	localparam int CU_W      = $clog2(NUM_CU);
	localparam int MAX_TESTS = 8;
	localparam int MAX_VERT  = 128;

	logic                clock;
	logic                rstn;
	logic                vertex_valid;
	logic [VERTEX_W-1:0] vertex_id;
	logic [DEGREE_W-1:0] vertex_degree;
	logic                vertex_stall;
	logic                read_cmd_valid;
	logic [VERTEX_W-1:0] read_cmd_vertex;
	logic [CU_W-1:0]     read_cmd_cu;
	logic                read_cmd_ready;
	logic                read_rsp_valid;
	logic [CU_W-1:0]     read_rsp_cu;
	logic [COUNT_W-1:0]  vertex_done_count;
	logic [COUNT_W-1:0]  edge_done_count;

	// Test records loaded from the data file
	string               test_name [MAX_TESTS];
	int                  test_stall [MAX_TESTS];
	int                  test_first [MAX_TESTS];
	int                  test_count [MAX_TESTS];
	int                  test_exp_v [MAX_TESTS];
	int                  test_exp_e [MAX_TESTS];
	logic [VERTEX_W-1:0] vert_id [MAX_VERT];
	logic [DEGREE_W-1:0] vert_deg [MAX_VERT];
	int                  num_tests = 0;
	int                  num_vert = 0;

	string               cur_name = "reset";
	logic                cur_stall = 1'b0;
	int                  value_errors = 0;
	int                  other_errors = 0;
	int                  cycle_limit = 500;
	int                  run_cycles = 0;
	int                  sent_total = 0;
	int                  exp_vertices = 0;
	int                  exp_edges = 0;

	// Response model state
	logic [31:0]         lfsr = 32'h6664fbf2;
	logic [VERTEX_W-1:0] pending [$];
	int                  rsp_due [$];
	logic [CU_W-1:0]     rsp_cu_q [$];
	logic [CU_W-1:0]     rsp_cu_now;
	logic [NUM_CU-1:0]   unit_busy = '0;
	int                  bus_cycle = 0;
	int                  stall_cycles = 0;
	int                  responses_sent = 0;
	int                  delay;
	logic                hold_valid = 1'b0;
	logic [VERTEX_W-1:0] hold_vertex;
	logic [CU_W-1:0]     hold_cu;

	clock_gen #(
		.PERIOD      (40),
		.RESET_CYCLES(16)
	) clock_gen_i (
		.clock(clock),
		.rstn (rstn)
	);

	graph_ctrl_top #(
		.NUM_CU   (NUM_CU),
		.JOB_DEPTH(JOB_DEPTH),
		.CMD_DEPTH(CMD_DEPTH)
	) dut_i (
		.clock            (clock),
		.rstn             (rstn),
		.vertex_valid     (vertex_valid),
		.vertex_id        (vertex_id),
		.vertex_degree    (vertex_degree),
		.vertex_stall     (vertex_stall),
		.read_cmd_valid   (read_cmd_valid),
		.read_cmd_vertex  (read_cmd_vertex),
		.read_cmd_cu      (read_cmd_cu),
		.read_cmd_ready   (read_cmd_ready),
		.read_rsp_valid   (read_rsp_valid),
		.read_rsp_cu      (read_rsp_cu),
		.vertex_done_count(vertex_done_count),
		.edge_done_count  (edge_done_count)
	);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic random_bit();
		lfsr = lfsr_next(lfsr);
		return lfsr[0];
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		value_errors++;
		$display("FAILED %s: %s expected %0h actual %0h", cur_name, what, expected, actual);
	endtask

	task automatic load_tests();
		int          fd;
		int          code;
		int          nv;
		int          ne;
		string       line;
		string       key;
		string       name;
		logic [31:0] pr [8];
		fd = $fopen("test/graph_ctrl_tests.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Cannot open the test data file");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			key = "";
			code = $sscanf(line, "%s", key);
			if (key == "test") begin
				code = $sscanf(line, "%s %s %d", key, name, nv);
				test_name[num_tests]  = name;
				test_stall[num_tests] = nv;
				test_first[num_tests] = num_vert;
				test_count[num_tests] = 0;
				num_tests++;
			end else if (key == "v") begin
				code = $sscanf(line, "%s %h %h %h %h %h %h %h %h", key,
					pr[0], pr[1], pr[2], pr[3], pr[4], pr[5], pr[6], pr[7]);
				for (int k = 0; k < (code - 1) / 2; k++) begin
					vert_id[num_vert]  = pr[2 * k][VERTEX_W-1:0];
					vert_deg[num_vert] = pr[2 * k + 1][DEGREE_W-1:0];
					num_vert++;
					test_count[num_tests - 1]++;
				end
			end else if (key == "total") begin
				code = $sscanf(line, "%s %d %d", key, nv, ne);
				test_exp_v[num_tests - 1] = nv;
				test_exp_e[num_tests - 1] = ne;
			end
		end
		$fclose(fd);
	endtask

	// Transferred command must match a vertex still outstanding
	task automatic check_command(input logic [VERTEX_W-1:0] vertex, input logic [CU_W-1:0] cu);
		int found;
		found = -1;
		foreach (pending[i]) begin
			if (found < 0 && pending[i] == vertex) begin
				found = i;
			end
		end
		if (found < 0) begin
			other_errors++;
			$display("%s: command for vertex %h that was not sent or already commanded",
				cur_name, vertex);
		end else begin
			pending.delete(found);
		end
		// A unit has one command outstanding at a time
		if ($isunknown(cu)) begin
			other_errors++;
			$display("%s: command carries an unknown unit id", cur_name);
		end else begin
			if (unit_busy[cu]) begin
				other_errors++;
				$display("%s: command from unit %0d which still awaits its response",
					cur_name, cu);
			end
			unit_busy[cu] = 1'b1;
		end
	endtask

	task automatic run_test(input int t);
		int idx;
		int last;
		int stall_start;
		@(posedge clock);
		cur_name  <= test_name[t];
		cur_stall <= (test_stall[t] != 0);
		stall_start = stall_cycles;
		idx  = test_first[t];
		last = test_first[t] + test_count[t];
		if (test_count[t] != test_exp_v[t]) begin
			other_errors++;
			$display("Data file test %s lists %0d vertices but its total says %0d",
				test_name[t], test_count[t], test_exp_v[t]);
		end
		while (idx < last) begin
			@(posedge clock);
			if (vertex_stall) begin
				vertex_valid <= 1'b0;
			end else begin
				vertex_valid  <= 1'b1;
				vertex_id     <= vert_id[idx];
				vertex_degree <= vert_deg[idx];
				pending.push_back(vert_id[idx]);
				idx++;
			end
		end
		@(posedge clock);
		vertex_valid <= 1'b0;
		sent_total   += test_count[t];
		exp_vertices += test_exp_v[t];
		exp_edges    += test_exp_e[t];
		// Last response, then hit register, worker counters and summed counts
		wait (responses_sent == sent_total);
		repeat (4) @(posedge clock);
		if (vertex_done_count !== COUNT_W'(exp_vertices)) begin
			report_mismatch("vertex_done_count", exp_vertices, vertex_done_count);
		end
		if (edge_done_count !== COUNT_W'(exp_edges)) begin
			report_mismatch("edge_done_count", exp_edges, edge_done_count);
		end
		if (pending.size() != 0) begin
			other_errors++;
			$display("%s: %0d vertices were sent but never commanded", test_name[t], pending.size());
		end
		if (test_stall[t] != 0 && test_count[t] > JOB_DEPTH + NUM_CU &&
				stall_cycles == stall_start) begin
			other_errors++;
			$display("%s: vertex_stall never rose although the jobs overfilled the buffer",
				test_name[t]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Command port and response model
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (!rstn) begin
			read_cmd_ready <= 1'b0;
			read_rsp_valid <= 1'b0;
			read_rsp_cu    <= '0;
			hold_valid = 1'b0;
		end else begin
			bus_cycle++;
			if (vertex_stall) begin
				stall_cycles++;
			end
			// Stalled command must not change
			if (hold_valid) begin
				if (!read_cmd_valid) begin
					other_errors++;
					$display("%s: read_cmd_valid dropped while read_cmd_ready was low", cur_name);
				end
				if (read_cmd_vertex !== hold_vertex) begin
					report_mismatch("held read_cmd_vertex", hold_vertex, read_cmd_vertex);
				end
				if (read_cmd_cu !== hold_cu) begin
					report_mismatch("held read_cmd_cu", hold_cu, read_cmd_cu);
				end
			end
			hold_valid  = read_cmd_valid && !read_cmd_ready;
			hold_vertex = read_cmd_vertex;
			hold_cu     = read_cmd_cu;
			if (read_cmd_valid && read_cmd_ready) begin
				check_command(read_cmd_vertex, read_cmd_cu);
				delay = random_bit();
				delay = 2 * delay + random_bit() + 1;
				rsp_due.push_back(bus_cycle + delay);
				rsp_cu_q.push_back(read_cmd_cu);
			end
			// One response per cycle, in command order
			if (rsp_due.size() > 0 && rsp_due[0] <= bus_cycle) begin
				rsp_cu_now = rsp_cu_q.pop_front();
				read_rsp_valid <= 1'b1;
				read_rsp_cu    <= rsp_cu_now;
				unit_busy[rsp_cu_now] = 1'b0;
				void'(rsp_due.pop_front());
				responses_sent++;
			end else begin
				read_rsp_valid <= 1'b0;
			end
			// Ready high one cycle in four on average
			if (cur_stall) begin
				read_cmd_ready <= random_bit() & random_bit();
			end else begin
				read_cmd_ready <= 1'b1;
			end
		end
	end

	always @(posedge clock) begin
		run_cycles++;
		if (run_cycles > cycle_limit) begin
			$display("Timeout: run stopped after %0d cycles", run_cycles);
			$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		vertex_valid   = 1'b0;
		vertex_id      = '0;
		vertex_degree  = '0;
		read_cmd_ready = 1'b0;
		read_rsp_valid = 1'b0;
		read_rsp_cu    = '0;
		load_tests();
		cycle_limit = 60 * num_vert + 500;
		if (num_tests == 0) begin
			other_errors++;
			$display("No tests were loaded from the data file");
		end
		wait (rstn === 1'b1);
		@(posedge clock);
		if (vertex_stall !== 1'b0) begin
			report_mismatch("vertex_stall", 0, vertex_stall);
		end
		if (read_cmd_valid !== 1'b0) begin
			report_mismatch("read_cmd_valid", 0, read_cmd_valid);
		end
		if (vertex_done_count !== '0) begin
			report_mismatch("vertex_done_count", 0, vertex_done_count);
		end
		if (edge_done_count !== '0) begin
			report_mismatch("edge_done_count", 0, edge_done_count);
		end
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
rtl/graph_ctrl_pkg.sv
rtl/sync_fifo.sv
rtl/rr_arbiter.sv
rtl/vertex_dispatch.sv
rtl/vertex_worker.sv
rtl/compute_array.sv
rtl/read_command_merge.sv
rtl/graph_ctrl_top.sv
test/clock_gen.sv
test/tb_graph_ctrl.sv

//--- test/graph_ctrl_tests.txt
# test <name> <stall mode 0|1>, then v lines of up to four <vertex hex> <degree hex> pairs
# total <vertex count> <degree sum>, both decimal, closes each test
test basic 0
v 0010 03 0011 00 0012 1f 0013 08
total 4 42
test burst 0
v 0100 01 0101 02 0102 04 0103 08
v 0104 10 0105 20 0106 40 0107 80
v 0108 ff 0109 7e 010a 05 010b 0c
total 12 653
test stall 1
v 0200 11 0201 22 0202 33 0203 44
v 0204 55 0205 66 0206 77 0207 88
v 0208 99 0209 aa 020a bb 020b cc
v 020c dd 020d ee 020e ff 020f 01
v 0210 02 0211 03 0212 04 0213 05
v 0214 06 0215 07 0216 08 0217 09
total 24 2085
